// ==== rvCore_defs.svh ====
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Datapath and instruction width
`define XLEN 32

// Integer register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// Data memory depth in 32-bit words
`define DMEM_WORDS 16

`endif

// ==== rvPkg.sv ====
`include "rvCore_defs.svh"

package rvPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings

    typedef enum logic [6:0] {
        opLoad  = 7'b0000011,
        opImm   = 7'b0010011,
        opStore = 7'b0100011,
        opReg   = 7'b0110011
    } opcodeE;

    // {funct7[5], funct3} of the matching R-type op
    typedef enum logic [3:0] {
        aluAdd = 4'b0000,
        aluSll = 4'b0001,
        aluXor = 4'b0100,
        aluSrl = 4'b0101,
        aluOr  = 4'b0110,
        aluAnd = 4'b0111,
        aluSub = 4'b1000,
        aluSra = 4'b1101
    } aluOpE;

    typedef enum logic {
        wbAlu = 1'b0,
        wbMem = 1'b1
    } wbSrcE;

    ////////////////////////////////////////////////////////////////////////////
    // Stage bundles

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] word;
    } instrInT;

    typedef struct packed {
        logic                   valid;
        logic                   regWrite;
        logic                   memRead;
        logic                   memWrite;
        wbSrcE                  wbSrc;
        aluOpE                  aluOp;
        logic                   useImm;   // Operand B from imm
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rs1Val;
        logic [`XLEN-1:0]       rs2Val;
        logic [`XLEN-1:0]       imm;
    } idExT;

    typedef struct packed {
        logic                   valid;
        logic                   regWrite;
        logic                   memRead;
        logic                   memWrite;
        wbSrcE                  wbSrc;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       aluResult;  // Also the byte address
        logic [`XLEN-1:0]       storeData;
    } exMemT;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wbT;

endpackage

// ==== registerFile.sv ====
`timescale 1ns/10ps
`include "rvCore_defs.svh"

module registerFile import rvPkg::*; (
    input  logic                   clock,
    input  logic                   arstN,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data,
    input  wbT                     wr
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // x0 is cleared on reset and never written
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && (wr.rd != '0)) begin
            regs[wr.rd] <= wr.data;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    // Decode masks rd == 0 three stages back
    assert property (@(posedge clock) disable iff (!arstN) wr.valid |-> (wr.rd != '0))
        else $error("writeback to x0 reached the register file");

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/10ps
`include "rvCore_defs.svh"

module decodeStage import rvPkg::*; (
    input  logic                   clock,
    input  logic                   arstN,
    input  instrInT                instr,
    output logic [`REG_ADDR_W-1:0] rs1Addr,
    output logic [`REG_ADDR_W-1:0] rs2Addr,
    input  logic [`XLEN-1:0]       rs1Data,
    input  logic [`XLEN-1:0]       rs2Data,
    output idExT                   idEx
);

    instrInT                instrQ;
    opcodeE                 opcode;
    logic [2:0]             funct3;
    logic                   bit30;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   regWrite;
    logic                   memRead;
    logic                   memWrite;
    wbSrcE                  wbSrc;
    aluOpE                  aluOp;
    logic                   useImm;
    logic [`XLEN-1:0]       imm;

    // Shared by R-type and immediate ops
    function automatic aluOpE aluSel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            3'b111:  return aluAnd;
            default: return aluAdd;   // slt/sltu not supported
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Instruction capture

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            instrQ.valid <= 1'b0;
        end else begin
            instrQ <= instr;
        end
    end

    assign opcode  = opcodeE'(instrQ.word[6:0]);
    assign funct3  = instrQ.word[14:12];
    assign bit30   = instrQ.word[30];
    assign rd      = instrQ.word[11:7];
    assign rs1Addr = instrQ.word[19:15];
    assign rs2Addr = instrQ.word[24:20];

    ////////////////////////////////////////////////////////////////////////////
    // Control and immediate

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        wbSrc    = wbAlu;
        aluOp    = aluAdd;   // Address add for loads and stores
        useImm   = 1'b0;
        imm      = {{20{instrQ.word[31]}}, instrQ.word[31:20]};
        case (opcode)
            opLoad: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                wbSrc    = wbMem;
                useImm   = 1'b1;
            end
            opImm: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                aluOp    = aluSel(funct3, (funct3 == 3'b101) && bit30);
            end
            opStore: begin
                memWrite = 1'b1;
                useImm   = 1'b1;
                imm      = {{20{instrQ.word[31]}}, instrQ.word[31:25], instrQ.word[11:7]};
            end
            opReg: begin
                regWrite = 1'b1;
                aluOp    = aluSel(funct3, bit30);
            end
            default: ;   // Unknown opcode is a no-op
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode/execute register

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            idEx.valid    <= 1'b0;
            idEx.regWrite <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
        end else begin
            idEx.valid    <= instrQ.valid;
            idEx.regWrite <= instrQ.valid && regWrite && (rd != '0);
            idEx.memRead  <= instrQ.valid && memRead;
            idEx.memWrite <= instrQ.valid && memWrite;
            idEx.wbSrc    <= wbSrc;
            idEx.aluOp    <= aluOp;
            idEx.useImm   <= useImm;
            idEx.rd       <= rd;
            idEx.rs1Val   <= rs1Data;
            idEx.rs2Val   <= rs2Data;
            idEx.imm      <= imm;
        end
    end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/10ps
`include "rvCore_defs.svh"

module executeStage import rvPkg::*; (
    input  logic  clock,
    input  logic  arstN,
    input  idExT  idEx,
    output exMemT exMem
);

    logic [`XLEN-1:0] opB;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] aluResult;

    assign opB   = idEx.useImm ? idEx.imm : idEx.rs2Val;
    assign shamt = opB[4:0];   // Low 5 bits only

    ////////////////////////////////////////////////////////////////////////////
    // ALU

    always_comb begin
        case (idEx.aluOp)
            aluAdd:  aluResult = idEx.rs1Val + opB;
            aluSub:  aluResult = idEx.rs1Val - opB;
            aluAnd:  aluResult = idEx.rs1Val & opB;
            aluOr:   aluResult = idEx.rs1Val | opB;
            aluXor:  aluResult = idEx.rs1Val ^ opB;
            aluSll:  aluResult = idEx.rs1Val << shamt;
            aluSrl:  aluResult = idEx.rs1Val >> shamt;
            aluSra:  aluResult = $signed(idEx.rs1Val) >>> shamt;
            default: aluResult = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Execute/memory register

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            exMem.valid    <= 1'b0;
            exMem.regWrite <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
        end else begin
            exMem.valid     <= idEx.valid;
            exMem.regWrite  <= idEx.regWrite;
            exMem.memRead   <= idEx.memRead;
            exMem.memWrite  <= idEx.memWrite;
            exMem.wbSrc     <= idEx.wbSrc;
            exMem.rd        <= idEx.rd;
            exMem.aluResult <= aluResult;
            exMem.storeData <= idEx.rs2Val;   // sw data is rs2 itself
        end
    end

endmodule

// ==== memoryStage.sv ====
`timescale 1ns/10ps
`include "rvCore_defs.svh"

module memoryStage import rvPkg::*; (
    input  logic  clock,
    input  logic  arstN,
    input  exMemT exMem,
    output wbT    wb
);

    localparam int IdxW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] dmem [`DMEM_WORDS];
    logic [IdxW-1:0]  wordIdx;
    logic [`XLEN-1:0] rdData;

    assign wordIdx = exMem.aluResult[IdxW+1:2];   // Byte address to wrapping word index

    always_ff @(posedge clock) begin
        if (exMem.valid && exMem.memWrite) begin
            dmem[wordIdx] <= exMem.storeData;
        end
    end

    assign rdData = dmem[wordIdx];

    ////////////////////////////////////////////////////////////////////////////
    // Memory/writeback register

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= exMem.valid && exMem.regWrite;
            wb.rd    <= exMem.rd;
            wb.data  <= (exMem.wbSrc == wbMem) ? rdData : exMem.aluResult;
        end
    end

    // Word accesses only
    assert property (@(posedge clock) disable iff (!arstN)
        (exMem.valid && (exMem.memRead || exMem.memWrite)) |-> (exMem.aluResult[1:0] == 2'b00))
        else $error("misaligned word access at %h", exMem.aluResult);

endmodule

// ==== rvPipeline.sv ====
`timescale 1ns/10ps
`include "rvCore_defs.svh"

module rvPipeline import rvPkg::*; (
    input  logic    clock,
    input  logic    arstN,
    input  instrInT instr,
    output wbT      wb
);

    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;
    idExT                   idEx;
    exMemT                  exMem;

    registerFile regFile (
        .clock   (clock),
        .arstN   (arstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wr      (wb)   // Retiring result doubles as write port
    );

    decodeStage decode (
        .clock   (clock),
        .arstN   (arstN),
        .instr   (instr),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .idEx    (idEx)
    );

    executeStage execute (
        .clock (clock),
        .arstN (arstN),
        .idEx  (idEx),
        .exMem (exMem)
    );

    memoryStage memory (
        .clock (clock),
        .arstN (arstN),
        .exMem (exMem),
        .wb    (wb)
    );

endmodule

// ==== rvPipelineTb.sv ====
`timescale 1ns/10ps
`include "rvCore_defs.svh"

module rvPipelineTb import rvPkg::*; ();

    localparam int NumRand = 20;
    localparam logic [6:0] OpImm  = 7'b0010011;
    localparam logic [6:0] OpLoad = 7'b0000011;

    typedef struct packed {
        int               test;
        logic [31:0]      word;
        int               idle;    // Idle cycles after issue
        int               expWb;
        int               rd;
        logic [31:0]      data;
    } rowT;

    typedef struct packed {
        int               due;     // Cycle in which wb must pulse
        int               rd;
        logic [31:0]      data;
    } sbT;

    logic    clock = 1'b0;
    logic    arstN;
    instrInT instr;
    wbT      wb;

    rowT    rows [$];
    sbT     sb [$];
    int     cycle = 0;
    int     errors = 0;
    int     checks = 0;
    integer seed = 32'h8e66eb8f;
    string  testName [6] = '{"reset and x0 add", "immediate ops", "register ops",
                             "store and load", "writes to x0", "back-to-back addi"};

    rvPipeline dut (
        .clock (clock),
        .arstN (arstN),
        .instr (instr),
        .wb    (wb)
    );

    initial begin
        forever #4 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Encoders and table

    function automatic logic [31:0] encodeR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] encodeI(int imm, int rs1, int f3, int rd,
                                            logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encodeS(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    task automatic addRow(int test, logic [31:0] word, int idle, int expWb, int rd,
                          logic [31:0] data);
        rows.push_back('{test: test, word: word, idle: idle, expWb: expWb, rd: rd,
                         data: data});
    endtask

    task automatic buildTable();
        addRow(1, encodeR(0, 0, 0, 0, 5), 3, 1, 5, 32'h0000_0000);
        addRow(2, encodeI('h5a3, 0, 0, 1, OpImm), 3, 1, 1, 32'h0000_05a3);   // addi
        addRow(2, encodeI(-8, 0, 0, 2, OpImm), 3, 1, 2, 32'hffff_fff8);
        addRow(2, encodeI('h0f0, 1, 7, 3, OpImm), 3, 1, 3, 32'h0000_00a0);   // andi
        addRow(2, encodeI(-256, 1, 6, 4, OpImm), 3, 1, 4, 32'hffff_ffa3);    // ori
        addRow(2, encodeI('h0ff, 2, 4, 6, OpImm), 3, 1, 6, 32'hffff_ff07);   // xori
        addRow(2, encodeI(4, 1, 1, 7, OpImm), 3, 1, 7, 32'h0000_5a30);       // slli
        addRow(2, encodeI(28, 2, 5, 8, OpImm), 3, 1, 8, 32'h0000_000f);      // srli
        addRow(2, encodeI('h402, 2, 5, 9, OpImm), 3, 1, 9, 32'hffff_fffe);   // srai
        addRow(3, encodeR(0, 2, 1, 0, 10), 3, 1, 10, 32'h0000_059b);
        addRow(3, encodeR('h20, 2, 1, 0, 11), 3, 1, 11, 32'h0000_05ab);      // sub
        addRow(3, encodeR(0, 2, 1, 7, 12), 3, 1, 12, 32'h0000_05a0);
        addRow(3, encodeR(0, 2, 1, 6, 13), 3, 1, 13, 32'hffff_fffb);
        addRow(3, encodeR(0, 2, 1, 4, 14), 3, 1, 14, 32'hffff_fa5b);
        addRow(3, encodeR(0, 8, 2, 1, 15), 3, 1, 15, 32'hfffc_0000);         // sll by 15
        addRow(3, encodeR(0, 8, 2, 5, 16), 3, 1, 16, 32'h0001_ffff);
        addRow(3, encodeR('h20, 8, 2, 5, 17), 3, 1, 17, 32'hffff_ffff);      // sra
        addRow(4, encodeS(8, 1, 0), 3, 0, 0, 32'h0);                         // word 2
        addRow(4, encodeS(36, 2, 0), 3, 0, 0, 32'h0);                        // word 9
        addRow(4, encodeI(8, 0, 2, 18, OpLoad), 3, 1, 18, 32'h0000_05a3);
        addRow(4, encodeI(36, 0, 2, 19, OpLoad), 3, 1, 19, 32'hffff_fff8);
        addRow(5, encodeI('h111, 1, 0, 0, OpImm), 3, 0, 0, 32'h0);
        addRow(5, encodeR(0, 2, 1, 0, 0), 3, 0, 0, 32'h0);
        addRow(5, encodeR(0, 0, 0, 0, 21), 3, 1, 21, 32'h0000_0000);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Driving and checking

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic issue(logic [31:0] word, int idle, int expWb, int rd, logic [31:0] data);
        @(posedge clock);
        instr <= '{valid: 1'b1, word: word};
        if (expWb != 0) begin
            sb.push_back('{due: cycle + 5, rd: rd, data: data});
        end
        repeat (idle) begin
            @(posedge clock);
            instr.valid <= 1'b0;
        end
    endtask

    task automatic finishTest(int test, int errStart);
        @(posedge clock);
        instr.valid <= 1'b0;
        while (sb.size() != 0) @(negedge clock);
        repeat (5) @(negedge clock);   // Catch stray pulses
        $display("test %0d (%s) done, %0d errors", test, testName[test-1], errors - errStart);
    endtask

    // Scoreboard sampled mid-cycle
    always @(negedge clock) begin
        while (sb.size() != 0 && sb[0].due < cycle) begin
            $display("Missing writeback for x%0d due in cycle %0d", sb[0].rd, sb[0].due);
            errors++;
            void'(sb.pop_front());
        end
        if (wb.valid === 1'b1 && sb.size() != 0 && sb[0].due == cycle) begin
            check("wb.rd", {27'd0, wb.rd}, sb[0].rd);
            check("wb.data", wb.data, sb[0].data);
            void'(sb.pop_front());
        end else if (wb.valid !== 1'b0) begin
            $display("Unexpected writeback (valid %b) to x%0d in cycle %0d",
                     wb.valid, wb.rd, cycle);
            errors++;
        end
    end

    initial begin
        int prevTest;
        int errStart;
        int r;
        buildTable();
        arstN = 1'b0;
        instr = '0;
        repeat (8) @(posedge clock);
        arstN <= 1'b1;
        prevTest = rows[0].test;
        errStart = 0;
        foreach (rows[i]) begin
            if (rows[i].test != prevTest) begin
                finishTest(prevTest, errStart);
                prevTest = rows[i].test;
                errStart = errors;
            end
            issue(rows[i].word, rows[i].idle, rows[i].expWb, rows[i].rd, rows[i].data);
        end
        finishTest(prevTest, errStart);
        errStart = errors;
        for (int i = 0; i < NumRand; i++) begin
            r = $random(seed);
            issue(encodeI(r, 0, 0, (i % 31) + 1, OpImm), 0, 1, (i % 31) + 1,
                  {{20{r[11]}}, r[11:0]});
        end
        finishTest(6, errStart);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #1;
        #((rows.size() + NumRand) * 10 * 8 + 200);
        $display("Watchdog timeout, pipeline did not finish the tests in time");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
rvPkg.sv
registerFile.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
rvPipeline.sv
rvPipelineTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      = rvPipelineTb
FILELIST = sources.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir
